//--- vec_unit_defines.svh
`ifndef VEC_UNIT_DEFINES_SVH
`define VEC_UNIT_DEFINES_SVH

// register file geometry
`define VEC_NUM_REGS 32
`define VEC_REG_BITS 128
`define VEC_LANES    2

// element offsets and vl, max vl is 128
`define VEC_OFS_BITS 8

// APB register map
`define VEC_A_CTRL   32'h0000_0000
`define VEC_A_CFG    32'h0000_0004
`define VEC_A_REGS   32'h0000_0008
`define VEC_A_STATUS 32'h0000_000C
`define VEC_A_ESEL   32'h0000_0010
`define VEC_A_EDATA  32'h0000_0014

`endif

//--- vec_unit_pkg.sv
package vec_unit_pkg;

  // element width, one width for every operand
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // lane operations
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VXOR  = 3'd3,
    VMSEQ = 3'd4
  } vop_t;

  // run control
  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } seq_state_t;

endpackage

//--- vec_lane_alu.sv
`timescale 1ns/1ns

module vec_lane_alu (
  input  vec_unit_pkg::vop_t op,
  input  vec_unit_pkg::sew_t sew,
  input  logic [31:0]        a,
  input  logic [31:0]        b,
  output logic [31:0]        result
);

  import vec_unit_pkg::*;

  logic [31:0] width_mask;
  logic [31:0] ta;
  logic [31:0] tb;
  logic [31:0] raw;

  always_comb begin
    case (sew)
      SEW8:    width_mask = 32'h0000_00ff;
      SEW16:   width_mask = 32'h0000_ffff;
      default: width_mask = 32'hffff_ffff;
    endcase
  end

  // a is the vs2 element, b the vs1 element
  assign ta = a & width_mask;
  assign tb = b & width_mask;

  always_comb begin
    case (op)
      VADD:    raw = ta + tb;
      VSUB:    raw = ta - tb;
      VAND:    raw = ta & tb;
      VXOR:    raw = ta ^ tb;
      VMSEQ:   raw = {31'h0, ta == tb};
      default: raw = 32'h0;
    endcase
  end

  // compare result is a single bit already
  assign result = raw & width_mask;

endmodule

//--- vec_reg_file.sv
`timescale 1ns/1ns

`include "vec_unit_defines.svh"

module vec_reg_file (
  input  logic                                CLK,
  input  logic                                nRST,
  input  vec_unit_pkg::sew_t                  sew,
  input  logic [`VEC_OFS_BITS-1:0]            vl,
  input  logic                                single_bit_write,
  input  logic [`VEC_LANES-1:0]               wen,
  input  logic [4:0]                          vd,
  input  logic [`VEC_OFS_BITS-1:0]            vd_offset,
  input  logic [`VEC_LANES-1:0][31:0]         w_data,
  input  logic [4:0]                          vs1,
  input  logic [`VEC_OFS_BITS-1:0]            vs1_offset,
  input  logic [4:0]                          vs2,
  input  logic [`VEC_OFS_BITS-1:0]            vs2_offset,
  output logic [`VEC_LANES-1:0][31:0]         vs1_data,
  output logic [`VEC_LANES-1:0][31:0]         vs2_data,
  output logic [`VEC_LANES-1:0]               vs2_mask
);

  import vec_unit_pkg::*;

  logic [`VEC_REG_BITS-1:0] regs [`VEC_NUM_REGS];

  // per lane offsets, one bit wider so offset+1 never wraps
  logic [`VEC_OFS_BITS:0] vd_ofs  [`VEC_LANES];
  logic [`VEC_OFS_BITS:0] vs1_ofs [`VEC_LANES];
  logic [`VEC_OFS_BITS:0] vs2_ofs [`VEC_LANES];

  // {register, byte position} of each lane element
  logic [8:0] vd_loc  [`VEC_LANES];
  logic [8:0] vs1_loc [`VEC_LANES];
  logic [8:0] vs2_loc [`VEC_LANES];

  logic [`VEC_LANES-1:0] wr_ok;

  // element offset to register step and byte within the register;
  // a step past the base register carries into the next one of the group
  function automatic logic [8:0] elem_loc(input logic [4:0] base,
                                          input logic [`VEC_OFS_BITS:0] ofs,
                                          input sew_t s);
    logic [8:0] byte_addr;
    logic [4:0] reg_num;
    case (s)
      SEW16:   byte_addr = 9'(ofs) << 1;
      SEW32:   byte_addr = 9'(ofs) << 2;
      default: byte_addr = 9'(ofs);
    endcase
    reg_num = base + byte_addr[8:4];
    return {reg_num, byte_addr[3:0]};
  endfunction

  // zero-extended element from one register row
  function automatic logic [31:0] read_elem(input logic [`VEC_REG_BITS-1:0] row,
                                            input logic [3:0] byte_pos,
                                            input sew_t s);
    logic [6:0] bit_pos;
    bit_pos = {byte_pos, 3'b000};
    case (s)
      SEW8:    return {24'h0, row[bit_pos +: 8]};
      SEW16:   return {16'h0, row[bit_pos +: 16]};
      SEW32:   return row[bit_pos +: 32];
      default: return 32'h0;
    endcase
  endfunction

  for (genvar l = 0; l < `VEC_LANES; l++) begin : g_lane
    assign vd_ofs[l]  = {1'b0, vd_offset}  + (`VEC_OFS_BITS+1)'(l);
    assign vs1_ofs[l] = {1'b0, vs1_offset} + (`VEC_OFS_BITS+1)'(l);
    assign vs2_ofs[l] = {1'b0, vs2_offset} + (`VEC_OFS_BITS+1)'(l);

    assign vd_loc[l]  = elem_loc(vd,  vd_ofs[l],  sew);
    assign vs1_loc[l] = elem_loc(vs1, vs1_ofs[l], sew);
    assign vs2_loc[l] = elem_loc(vs2, vs2_ofs[l], sew);

    // writes at or past vl are dropped
    assign wr_ok[l] = wen[l] && (vd_ofs[l] < {1'b0, vl});

    assign vs1_data[l] = read_elem(regs[vs1_loc[l][8:4]], vs1_loc[l][3:0], sew);
    assign vs2_data[l] = read_elem(regs[vs2_loc[l][8:4]], vs2_loc[l][3:0], sew);

    // mask bits of v0, one bit per element
    assign vs2_mask[l] = regs[0][vs2_ofs[l][6:0]];
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `VEC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int l = 0; l < `VEC_LANES; l++) begin
        if (wr_ok[l]) begin
          if (single_bit_write) begin
            // mask result, bit o of vd (vl <= 128 keeps it in vd)
            regs[vd][vd_ofs[l][6:0]] <= w_data[l][0];
          end else begin
            case (sew)
              SEW8:    regs[vd_loc[l][8:4]][{vd_loc[l][3:0], 3'b000} +: 8]  <= w_data[l][7:0];
              SEW16:   regs[vd_loc[l][8:4]][{vd_loc[l][3:0], 3'b000} +: 16] <= w_data[l][15:0];
              SEW32:   regs[vd_loc[l][8:4]][{vd_loc[l][3:0], 3'b000} +: 32] <= w_data[l];
              default: ;
            endcase
          end
        end
      end
    end
  end

endmodule

//--- vec_sequencer.sv
`timescale 1ns/1ns

`include "vec_unit_defines.svh"

module vec_sequencer (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        start,
  input  logic [`VEC_OFS_BITS-1:0]    vl,
  input  vec_unit_pkg::vop_t          op,
  input  logic                        vm,
  input  logic [4:0]                  vd,
  input  logic [4:0]                  vs1,
  input  logic [4:0]                  vs2,
  input  logic                        host_we,
  input  logic [4:0]                  host_vreg,
  input  logic [`VEC_OFS_BITS-1:0]    host_idx,
  input  logic [31:0]                 host_wdata,
  output logic                        busy,
  output logic                        done_pulse,
  output logic [`VEC_LANES-1:0]       rf_wen,
  output logic                        rf_single_bit,
  output logic [4:0]                  rf_vd,
  output logic [`VEC_OFS_BITS-1:0]    rf_vd_offset,
  output logic [4:0]                  rf_vs1,
  output logic [`VEC_OFS_BITS-1:0]    rf_vs1_offset,
  output logic [4:0]                  rf_vs2,
  output logic [`VEC_OFS_BITS-1:0]    rf_vs2_offset,
  output logic [`VEC_LANES-1:0][31:0] rf_w_data,
  input  logic [`VEC_LANES-1:0][31:0] alu_result,
  input  logic [`VEC_LANES-1:0]       mask
);

  import vec_unit_pkg::*;

  seq_state_t               state;
  logic [`VEC_OFS_BITS-1:0] ofs;
  logic [`VEC_OFS_BITS:0]   ofs_next;
  logic                     last_step;

  assign ofs_next  = {1'b0, ofs} + (`VEC_OFS_BITS+1)'(`VEC_LANES);
  // vl of 0 still takes one cycle
  assign last_step = ofs_next >= {1'b0, vl};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      ofs   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= RUN;
            ofs   <= '0;
          end
        end
        RUN: begin
          if (last_step) begin
            state <= IDLE;
            ofs   <= '0;
          end else begin
            ofs <= ofs_next[`VEC_OFS_BITS-1:0];
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy       = (state == RUN);
  assign done_pulse = (state == RUN) && last_step;

  // vs2 and its mask always follow the run offset
  assign rf_vs2        = vs2;
  assign rf_vs2_offset = ofs;

  always_comb begin
    if (state == RUN) begin
      rf_wen        = vm ? mask : '1;
      rf_single_bit = (op == VMSEQ);
      rf_vd         = vd;
      rf_vd_offset  = ofs;
      rf_vs1        = vs1;
      rf_vs1_offset = ofs;
      rf_w_data     = alu_result;
    end else begin
      // host element window on lane 0
      rf_wen        = {1'b0, host_we};
      rf_single_bit = 1'b0;
      rf_vd         = host_vreg;
      rf_vd_offset  = host_idx;
      rf_vs1        = host_vreg;
      rf_vs1_offset = host_idx;
      rf_w_data     = {32'h0, host_wdata};
    end
  end

endmodule

//--- vec_apb_regs.sv
`timescale 1ns/1ns

`include "vec_unit_defines.svh"

module vec_apb_regs (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [31:0]              paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  logic                     busy,
  input  logic                     done_pulse,
  input  logic [31:0]              elem_rdata,
  output logic [`VEC_OFS_BITS-1:0] vl,
  output vec_unit_pkg::sew_t       sew,
  output vec_unit_pkg::vop_t       op,
  output logic                     vm,
  output logic [4:0]               vd,
  output logic [4:0]               vs1,
  output logic [4:0]               vs2,
  output logic                     start,
  output logic                     host_we,
  output logic [4:0]               host_vreg,
  output logic [`VEC_OFS_BITS-1:0] host_idx,
  output logic [31:0]              host_wdata
);

  import vec_unit_pkg::*;

  logic access;
  logic mapped;
  logic locked;
  logic wr_ok;
  logic done_q;

  assign access = psel && penable;
  assign mapped = (paddr == `VEC_A_CTRL) || (paddr == `VEC_A_CFG) ||
                  (paddr == `VEC_A_REGS) || (paddr == `VEC_A_STATUS) ||
                  (paddr == `VEC_A_ESEL) || (paddr == `VEC_A_EDATA);
  // registers that must not change under a running sequence
  assign locked = (paddr == `VEC_A_CTRL) || (paddr == `VEC_A_CFG) ||
                  (paddr == `VEC_A_REGS) || (paddr == `VEC_A_EDATA);

  assign pready  = 1'b1;
  assign pslverr = access && (!mapped || (pwrite && busy && locked));
  assign wr_ok   = access && pwrite && !pslverr;

  assign start      = wr_ok && (paddr == `VEC_A_CTRL) && pwdata[0];
  assign host_we    = wr_ok && (paddr == `VEC_A_EDATA);
  assign host_wdata = pwdata;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl        <= '0;
      sew       <= SEW8;
      op        <= VADD;
      vm        <= 1'b0;
      vd        <= '0;
      vs1       <= '0;
      vs2       <= '0;
      host_vreg <= '0;
      host_idx  <= '0;
      done_q    <= 1'b0;
    end else begin
      if (wr_ok && (paddr == `VEC_A_CFG)) begin
        vl  <= pwdata[7:0];
        sew <= sew_t'(pwdata[9:8]);
        op  <= vop_t'(pwdata[14:12]);
        vm  <= pwdata[16];
      end
      if (wr_ok && (paddr == `VEC_A_REGS)) begin
        vd  <= pwdata[4:0];
        vs1 <= pwdata[12:8];
        vs2 <= pwdata[20:16];
      end
      if (wr_ok && (paddr == `VEC_A_ESEL)) begin
        host_vreg <= pwdata[4:0];
        host_idx  <= pwdata[15:8];
      end
      // sticky done, a new completion wins over the clearing read
      if (access && !pwrite && (paddr == `VEC_A_STATUS)) begin
        done_q <= 1'b0;
      end
      if (done_pulse) begin
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (paddr)
      `VEC_A_CFG:    prdata = {15'h0, vm, 1'b0, op, 2'b00, sew, vl};
      `VEC_A_REGS:   prdata = {11'h0, vs2, 3'b000, vs1, 3'b000, vd};
      `VEC_A_STATUS: prdata = {30'h0, done_q, busy};
      `VEC_A_ESEL:   prdata = {16'h0, host_idx, 3'b000, host_vreg};
      `VEC_A_EDATA:  prdata = elem_rdata;
      default:       prdata = 32'h0;
    endcase
  end

endmodule

//--- vec_unit_top.sv
`timescale 1ns/1ns

`include "vec_unit_defines.svh"

module vec_unit_top (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  import vec_unit_pkg::*;

  logic [`VEC_OFS_BITS-1:0]    vl;
  sew_t                        sew;
  vop_t                        op;
  logic                        vm;
  logic [4:0]                  vd;
  logic [4:0]                  vs1;
  logic [4:0]                  vs2;
  logic                        start;
  logic                        busy;
  logic                        done_pulse;
  logic                        host_we;
  logic [4:0]                  host_vreg;
  logic [`VEC_OFS_BITS-1:0]    host_idx;
  logic [31:0]                 host_wdata;
  logic [`VEC_LANES-1:0]       rf_wen;
  logic                        rf_single_bit;
  logic [4:0]                  rf_vd;
  logic [`VEC_OFS_BITS-1:0]    rf_vd_offset;
  logic [4:0]                  rf_vs1;
  logic [`VEC_OFS_BITS-1:0]    rf_vs1_offset;
  logic [4:0]                  rf_vs2;
  logic [`VEC_OFS_BITS-1:0]    rf_vs2_offset;
  logic [`VEC_LANES-1:0][31:0] rf_w_data;
  logic [`VEC_LANES-1:0][31:0] vs1_data;
  logic [`VEC_LANES-1:0][31:0] vs2_data;
  logic [`VEC_LANES-1:0]       vs2_mask;
  logic [`VEC_LANES-1:0][31:0] alu_result;

  vec_apb_regs apb_regs_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .busy       (busy),
    .done_pulse (done_pulse),
    .elem_rdata (vs1_data[0]),
    .vl         (vl),
    .sew        (sew),
    .op         (op),
    .vm         (vm),
    .vd         (vd),
    .vs1        (vs1),
    .vs2        (vs2),
    .start      (start),
    .host_we    (host_we),
    .host_vreg  (host_vreg),
    .host_idx   (host_idx),
    .host_wdata (host_wdata)
  );

  vec_sequencer sequencer_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .start         (start),
    .vl            (vl),
    .op            (op),
    .vm            (vm),
    .vd            (vd),
    .vs1           (vs1),
    .vs2           (vs2),
    .host_we       (host_we),
    .host_vreg     (host_vreg),
    .host_idx      (host_idx),
    .host_wdata    (host_wdata),
    .busy          (busy),
    .done_pulse    (done_pulse),
    .rf_wen        (rf_wen),
    .rf_single_bit (rf_single_bit),
    .rf_vd         (rf_vd),
    .rf_vd_offset  (rf_vd_offset),
    .rf_vs1        (rf_vs1),
    .rf_vs1_offset (rf_vs1_offset),
    .rf_vs2        (rf_vs2),
    .rf_vs2_offset (rf_vs2_offset),
    .rf_w_data     (rf_w_data),
    .alu_result    (alu_result),
    .mask          (vs2_mask)
  );

  // vs2 element is operand a, vs1 element operand b
  vec_lane_alu lane0_alu_i (
    .op     (op),
    .sew    (sew),
    .a      (vs2_data[0]),
    .b      (vs1_data[0]),
    .result (alu_result[0])
  );

  vec_lane_alu lane1_alu_i (
    .op     (op),
    .sew    (sew),
    .a      (vs2_data[1]),
    .b      (vs1_data[1]),
    .result (alu_result[1])
  );

  vec_reg_file reg_file_i (
    .CLK              (CLK),
    .nRST             (nRST),
    .sew              (sew),
    .vl               (vl),
    .single_bit_write (rf_single_bit),
    .wen              (rf_wen),
    .vd               (rf_vd),
    .vd_offset        (rf_vd_offset),
    .w_data           (rf_w_data),
    .vs1              (rf_vs1),
    .vs1_offset       (rf_vs1_offset),
    .vs2              (rf_vs2),
    .vs2_offset       (rf_vs2_offset),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .vs2_mask         (vs2_mask)
  );

endmodule

//--- vec_unit_tb.sv
`timescale 1ns/1ns

`include "vec_unit_defines.svh"

module vec_unit_tb;

  import vec_unit_pkg::*;

  logic        CLK;
  logic        nRST;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int checks = 0;
  int errors = 0;

  // stimulus source
  logic [31:0] lfsr = 32'hf9028b0d;

  // mirror of the register file contents
  logic [`VEC_REG_BITS-1:0] model [`VEC_NUM_REGS];

  // configuration as last written by the host
  logic [7:0] cur_vl;
  sew_t       cur_sew;
  vop_t       cur_op;
  logic       cur_vm;
  int         cur_vd;
  int         cur_vs1;
  int         cur_vs2;

  vec_unit_top dut_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // taps of x^32 + x^22 + x^2 + x + 1 with one step per bit
  function automatic logic [31:0] next_rand(input int nbits);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int sew_bytes(input sew_t s);
    case (s)
      SEW16:   return 2;
      SEW32:   return 4;
      default: return 1;
    endcase
  endfunction

  // element idx of the group at base carries into following registers
  function automatic void model_write(input int base, input int idx, input logic [31:0] data);
    int nb;
    int r;
    int pos;
    nb  = sew_bytes(cur_sew);
    r   = (base + (idx * nb) / 16) % `VEC_NUM_REGS;
    pos = ((idx * nb) % 16) * 8;
    for (int b = 0; b < nb * 8; b++) begin
      model[r][pos + b] = data[b];
    end
  endfunction

  function automatic logic [31:0] model_read(input int base, input int idx);
    int          nb;
    int          r;
    int          pos;
    logic [31:0] v;
    nb  = sew_bytes(cur_sew);
    r   = (base + (idx * nb) / 16) % `VEC_NUM_REGS;
    pos = ((idx * nb) % 16) * 8;
    v   = '0;
    for (int b = 0; b < nb * 8; b++) begin
      v[b] = model[r][pos + b];
    end
    return v;
  endfunction

  // a is the vs2 element and b the vs1 element
  function automatic logic [31:0] lane_op(input vop_t op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] m;
    logic [31:0] r;
    if (sew_bytes(cur_sew) == 4) begin
      m = 32'hffff_ffff;
    end else begin
      m = (32'h1 << (8 * sew_bytes(cur_sew))) - 32'h1;
    end
    case (op)
      VADD:    r = a + b;
      VSUB:    r = a - b;
      VAND:    r = a & b;
      VXOR:    r = a ^ b;
      default: r = {31'h0, a == b};
    endcase
    return r & m;
  endfunction

  // apply one run to the model element by element
  function automatic void model_run();
    logic [31:0] a;
    logic [31:0] b;
    for (int o = 0; o < cur_vl; o++) begin
      if (cur_vm && !model[0][o]) begin
        continue;
      end
      a = model_read(cur_vs2, o);
      b = model_read(cur_vs1, o);
      if (cur_op == VMSEQ) begin
        model[cur_vd][o] = (a == b);
      end else begin
        model_write(cur_vd, o, lane_op(cur_op, a, b));
      end
    end
  endfunction

  task automatic report_and_finish();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // called and returns 1 ns after a rising edge
  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic exp_err);
    int   cycles;
    logic err;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    cycles  = 0;
    @(negedge CLK);
    while (!pready && cycles < 16) begin
      @(negedge CLK);
      cycles++;
    end
    if (!pready) begin
      errors++;
      $display("APB write to 0x%08h never completed", addr);
      report_and_finish();
    end else begin
      err = pslverr;
      @(posedge CLK);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      check($sformatf("pslverr on write 0x%08h", addr), 32'(err), 32'(exp_err));
    end
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                          input logic exp_err);
    int   cycles;
    logic err;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    cycles  = 0;
    @(negedge CLK);
    while (!pready && cycles < 16) begin
      @(negedge CLK);
      cycles++;
    end
    data = prdata;
    if (!pready) begin
      errors++;
      $display("APB read of 0x%08h never completed", addr);
      report_and_finish();
    end else begin
      err = pslverr;
      @(posedge CLK);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      check($sformatf("pslverr on read 0x%08h", addr), 32'(err), 32'(exp_err));
    end
  endtask

  task automatic set_cfg(input logic [7:0] vl, input sew_t sew, input vop_t op,
                         input logic vm);
    apb_write(`VEC_A_CFG, (32'(vm) << 16) | (32'(op) << 12) | (32'(sew) << 8) | 32'(vl),
              1'b0);
    cur_vl  = vl;
    cur_sew = sew;
    cur_op  = op;
    cur_vm  = vm;
  endtask

  task automatic set_regs(input int vd, input int vs1, input int vs2);
    apb_write(`VEC_A_REGS, (vs2 << 16) | (vs1 << 8) | vd, 1'b0);
    cur_vd  = vd;
    cur_vs1 = vs1;
    cur_vs2 = vs2;
  endtask

  task automatic load_elem(input int vreg, input int idx, input logic [31:0] data);
    apb_write(`VEC_A_ESEL, (idx << 8) | vreg, 1'b0);
    apb_write(`VEC_A_EDATA, data, 1'b0);
    if (idx < cur_vl) begin
      model_write(vreg, idx, data);
    end
  endtask

  task automatic expect_elem(input int vreg, input int idx);
    logic [31:0] rd;
    apb_write(`VEC_A_ESEL, (idx << 8) | vreg, 1'b0);
    apb_read(`VEC_A_EDATA, rd, 1'b0);
    check($sformatf("v%0d[%0d]", vreg, idx), rd, model_read(vreg, idx));
  endtask

  // whole register as four 32-bit words
  task automatic expect_reg(input int vreg);
    set_cfg(cur_vl, SEW32, cur_op, cur_vm);
    for (int w = 0; w < 4; w++) begin
      expect_elem(vreg, w);
    end
  endtask

  task automatic fill_regs(input int base, input int count);
    set_cfg(8'd128, SEW32, VADD, 1'b0);
    for (int r = 0; r < count; r++) begin
      for (int w = 0; w < 4; w++) begin
        load_elem(base + r, w, next_rand(32));
      end
    end
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    polls = 0;
    st    = '0;
    while (!st[1] && polls < 200) begin
      apb_read(`VEC_A_STATUS, st, 1'b0);
      polls++;
    end
    if (!st[1]) begin
      errors++;
      $display("run did not report done in time");
      report_and_finish();
    end else begin
      check("busy after done", 32'(st[0]), 32'h0);
    end
  endtask

  task automatic run_op(input logic [7:0] vl, input sew_t sew, input vop_t op,
                        input logic vm);
    set_cfg(vl, sew, op, vm);
    apb_write(`VEC_A_CTRL, 32'h1, 1'b0);
    wait_done();
    model_run();
  endtask

  task automatic load_readback();
    // byte elements 13..18 cross from v4 into v5
    set_cfg(8'd128, SEW8, VADD, 1'b0);
    for (int i = 13; i < 19; i++) begin
      load_elem(4, i, next_rand(32));
    end
    for (int i = 13; i < 19; i++) begin
      expect_elem(4, i);
    end
    set_cfg(8'd128, SEW16, VADD, 1'b0);
    for (int i = 6; i < 10; i++) begin
      load_elem(6, i, next_rand(32));
    end
    for (int i = 6; i < 10; i++) begin
      expect_elem(6, i);
    end
    set_cfg(8'd128, SEW32, VADD, 1'b0);
    for (int i = 2; i < 6; i++) begin
      load_elem(8, i, next_rand(32));
    end
    for (int i = 2; i < 6; i++) begin
      expect_elem(8, i);
    end
    for (int r = 4; r < 10; r++) begin
      expect_reg(r);
    end
  endtask

  task automatic vl_gate();
    fill_regs(10, 1);
    set_cfg(8'd5, SEW16, VADD, 1'b0);
    load_elem(10, 3, next_rand(32));
    // index 5 and 7 sit at or past vl and must not land
    load_elem(10, 5, next_rand(32));
    load_elem(10, 7, next_rand(32));
    expect_elem(10, 3);
    expect_elem(10, 5);
    expect_elem(10, 7);
    expect_reg(10);
  endtask

  task automatic alu_ops();
    fill_regs(12, 6);
    set_regs(16, 14, 12);
    run_op(8'd21, SEW8, VADD, 1'b0);
    expect_reg(16);
    expect_reg(17);
    run_op(8'd10, SEW16, VSUB, 1'b0);
    expect_reg(16);
    expect_reg(17);
    run_op(8'd5, SEW32, VAND, 1'b0);
    expect_reg(16);
    expect_reg(17);
    run_op(8'd32, SEW8, VXOR, 1'b0);
    expect_reg(16);
    expect_reg(17);
    // empty run still completes
    run_op(8'd0, SEW32, VADD, 1'b0);
    expect_reg(16);
  endtask

  task automatic mask_compare();
    logic [15:0] a;
    logic [15:0] b;
    fill_regs(20, 1);
    set_cfg(8'd128, SEW16, VADD, 1'b0);
    for (int i = 0; i < 8; i++) begin
      a = 16'(next_rand(16));
      if (i % 3 == 1) begin
        b = a;
      end else begin
        b = a + 16'h1 + 16'(next_rand(8));
      end
      // upper half is outside the element
      load_elem(18, i, {16'(next_rand(16)), a});
      load_elem(19, i, {16'(next_rand(16)), b});
    end
    set_regs(20, 19, 18);
    run_op(8'd8, SEW16, VMSEQ, 1'b0);
    expect_reg(20);
  endtask

  task automatic masked_add();
    set_cfg(8'd128, SEW32, VADD, 1'b0);
    load_elem(0, 0, 32'ha5c3_0f69);
    load_elem(0, 1, 32'h3c96_e15a);
    fill_regs(22, 2);
    set_regs(22, 14, 12);
    run_op(8'd20, SEW8, VADD, 1'b1);
    expect_reg(22);
    expect_reg(23);
  endtask

  task automatic apb_rules();
    logic [31:0] cfg_val;
    logic [31:0] rd;
    set_regs(24, 16, 12);
    set_cfg(8'd64, SEW8, VXOR, 1'b0);
    cfg_val = (32'(VXOR) << 12) | (32'(SEW8) << 8) | 32'd64;
    apb_write(`VEC_A_CTRL, 32'h1, 1'b0);
    apb_write(`VEC_A_CFG, (32'(VAND) << 12) | (32'(SEW32) << 8) | 32'd3, 1'b1);
    apb_read(`VEC_A_CFG, rd, 1'b0);
    check("CFG after write during run", rd, cfg_val);
    apb_read(`VEC_A_STATUS, rd, 1'b0);
    check("STATUS during run", rd, 32'h1);
    apb_write(`VEC_A_REGS, 32'h0003_0201, 1'b1);
    apb_write(`VEC_A_EDATA, 32'h1234_5678, 1'b1);
    wait_done();
    // done is sticky only until it has been read once
    apb_read(`VEC_A_STATUS, rd, 1'b0);
    check("STATUS after done read", rd, 32'h0);
    model_run();
    for (int r = 24; r < 28; r++) begin
      expect_reg(r);
    end
    apb_read(32'h0000_0018, rd, 1'b1);
    apb_write(32'h0000_0040, 32'h0, 1'b1);
  endtask

  initial begin
    nRST    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    cur_vl  = '0;
    cur_sew = SEW8;
    cur_op  = VADD;
    cur_vm  = 1'b0;
    cur_vd  = 0;
    cur_vs1 = 0;
    cur_vs2 = 0;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      model[r] = '0;
    end
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(posedge CLK);
    #1;
    load_readback();
    vl_gate();
    alu_ops();
    mask_compare();
    masked_add();
    apb_rules();
    report_and_finish();
  end

endmodule

//--- vec_unit_top.f
+incdir+.
vec_unit_pkg.sv
vec_lane_alu.sv
vec_reg_file.sv
vec_sequencer.sv
vec_apb_regs.sv
vec_unit_top.sv
vec_unit_tb.sv

//--- Bender.yml
package:
  name: vec_unit

export_include_dirs:
  - .

sources:
  - vec_unit_pkg.sv
  - vec_lane_alu.sv
  - vec_reg_file.sv
  - vec_sequencer.sv
  - vec_apb_regs.sv
  - vec_unit_top.sv
  - target: simulation
    files:
      - vec_unit_tb.sv
